// File: tests/dma_vectors.txt
# T name word_addr length fast bytes...  (hex fields except length, fast 1 sends with no gaps)
# R name word_addr expected_word, O is the same read issued during the next transfer
T even_fill 10 8 0 11 22 33 44 55 66 77 88
R even_first 10 1122
R even_last 13 7788
T odd_prefill 20 6 0 a1 a2 a3 a4 a5 a6
T odd_pad 20 3 0 c1 c2 c3
R odd_head 20 c1c2
R odd_tail 21 c300
R odd_neighbor 22 a5a6
T zero_len 10 0 0
R zero_keep0 10 1122
R zero_keep1 11 3344
T burst 40 20 1 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14
R burst_first 40 0102
R burst_mid 44 090a
R burst_last 49 1314
O overlap_even 11 3344
O overlap_odd 21 c300
O overlap_burst 45 0b0c
O overlap_back 12 5566
T overlap 60 16 0 f0 e1 d2 c3 b4 a5 96 87 78 69 5a 4b 3c 2d 1e 0f
R overlap_first 60 f0e1
R overlap_last 67 1e0f
R final_even 13 7788
R final_burst 49 1314

// File: flist.f
src/sc64_mem_pkg.sv
src/sc64_dma_pkg.sv
src/fifo_byte_rx.sv
src/memory_dma.sv
src/memory_arbiter.sv
src/memory_bram.sv
src/dma_memory_top.sv
tests/dma_memory_asserts.sv
tests/dma_memory_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the DMA memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f flist.f \
        --top-module dma_memory_tb -o dma_memory_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dma_memory_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// File: tests/dma_memory_tb.sv
`timescale 1ns/1ns

module dma_memory_tb
    import sc64_mem_pkg::*;
    import sc64_dma_pkg::*;
();

    localparam int FIFO_DEPTH = 8;
    localparam int ADDR_WIDTH = 8;
    localparam string VECTOR_FILE = "tests/dma_vectors.txt";

    logic clk;
    logic reset;
    logic fifo_req;
    byte_t fifo_data;
    logic fifo_ack;
    logic dma_start;
    mem_addr_t dma_address;
    dma_length_t dma_length;
    logic dma_busy;
    logic n64_req;
    mem_addr_t n64_address;
    logic n64_ack;
    mem_data_t n64_rdata;

    // One entry per parsed vector line
    logic [7:0] cmd_kind [$];
    string cmd_name [$];
    mem_addr_t cmd_addr [$];
    int cmd_arg [$];
    bit cmd_fast [$];
    byte_t byte_pool [$];

    // Reads that run alongside the next transfer
    string overlap_name [$];
    mem_addr_t overlap_addr [$];
    mem_data_t overlap_data [$];

    mem_data_t model [mem_addr_t];
    int unsigned cycle_count = 0;
    int unsigned cycle_limit = 0;

    dma_memory_top #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .ADDR_WIDTH(ADDR_WIDTH)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .fifo_req(fifo_req),
        .fifo_data(fifo_data),
        .fifo_ack(fifo_ack),
        .dma_start(dma_start),
        .dma_address(dma_address),
        .dma_length(dma_length),
        .dma_busy(dma_busy),
        .n64_req(n64_req),
        .n64_address(n64_address),
        .n64_ack(n64_ack),
        .n64_rdata(n64_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if ((cycle_limit != 0) && (cycle_count >= cycle_limit)) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string test_name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch in %s", test_name);
        end
    endtask

    task automatic stop_on_bad_file(input string reason);
        $display("Vector file problem: %s", reason);
        $display("TEST FAILED");
        $fatal(1, "cannot use %s", VECTOR_FILE);
    endtask

    task automatic load_vectors();
        int fd;
        int count;
        int i;
        int value;
        int fast;
        logic [8*32-1:0] kind_tok;
        logic [8*32-1:0] name_tok;
        logic [8*256-1:0] rest;
        mem_addr_t addr;
        byte_t data;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            stop_on_bad_file("the file could not be opened");
        end
        while ($fscanf(fd, "%s", kind_tok) == 1) begin
            if (kind_tok == "#") begin
                count = $fgets(rest, fd);
            end else if (kind_tok == "T") begin
                count = $fscanf(fd, "%s %h %d %d", name_tok, addr, value, fast);
                if (count != 4) begin
                    stop_on_bad_file("a transfer line is incomplete");
                end
                cmd_kind.push_back(kind_tok[7:0]);
                cmd_name.push_back(string'(name_tok));
                cmd_addr.push_back(addr);
                cmd_arg.push_back(value);
                cmd_fast.push_back(fast != 0);
                for (i = 0; i < value; i++) begin
                    count = $fscanf(fd, "%h", data);
                    byte_pool.push_back(data);
                end
            end else if ((kind_tok == "R") || (kind_tok == "O")) begin
                count = $fscanf(fd, "%s %h %h", name_tok, addr, value);
                if (count != 3) begin
                    stop_on_bad_file("a read line is incomplete");
                end
                cmd_kind.push_back(kind_tok[7:0]);
                cmd_name.push_back(string'(name_tok));
                cmd_addr.push_back(addr);
                cmd_arg.push_back(value);
                cmd_fast.push_back(1'b0);
            end else begin
                stop_on_bad_file("a line has an unknown type");
            end
        end
        $fclose(fd);
    endtask

    task automatic send_stream(input byte_t bytes [$], input bit fast);
        int unsigned gap;
        foreach (bytes[i]) begin
            gap = fast ? 0 : ($urandom % 4);
            repeat (gap) @(posedge clk);
            fifo_data <= bytes[i];
            fifo_req <= 1'b1;
            do begin
                @(posedge clk);
            end while (!fifo_ack);
            gap = fast ? 0 : ($urandom % 3);
            repeat (gap) @(posedge clk);
            fifo_req <= 1'b0;
            do begin
                @(posedge clk);
            end while (fifo_ack);
        end
    endtask

    task automatic read_word(input mem_addr_t addr, output mem_data_t data);
        int unsigned gap;
        gap = $urandom % 4;
        repeat (gap) @(posedge clk);
        n64_address <= addr;
        n64_req <= 1'b1;
        do begin
            @(posedge clk);
        end while (!n64_ack);
        data = n64_rdata;
        n64_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (n64_ack);
    endtask

    task automatic start_transfer(input string test_name, input mem_addr_t addr, input int len);
        @(posedge clk);
        dma_address <= addr;
        dma_length <= dma_length_t'(len);
        dma_start <= 1'b1;
        @(posedge clk);
        dma_start <= 1'b0;
        @(posedge clk);
        check_value({test_name, "_busy"}, 16'd1, {15'd0, dma_busy});
    endtask

    // Full FIFO shows as req held high with no ack
    task automatic wait_for_stall();
        int stalled;
        stalled = 0;
        while (stalled < 8) begin
            @(posedge clk);
            if (fifo_req && !fifo_ack) begin
                stalled++;
            end else begin
                stalled = 0;
            end
        end
    endtask

    task automatic run_overlap_reads();
        mem_data_t data;
        while (overlap_addr.size() > 0) begin
            read_word(overlap_addr[0], data);
            check_value(overlap_name[0], overlap_data[0], data);
            overlap_name.delete(0);
            overlap_addr.delete(0);
            overlap_data.delete(0);
        end
    endtask

    task automatic run_transfer(input string test_name, input mem_addr_t addr, input int len,
                                input bit fast);
        byte_t bytes [$];
        mem_addr_t word_addr;
        mem_data_t data;
        int i;
        for (i = 0; i < len; i++) begin
            bytes.push_back(byte_pool.pop_front());
        end
        if (fast) begin
            // DMA starts only once the FIFO pushes back
            fork
                send_stream(bytes, 1'b1);
                begin
                    wait_for_stall();
                    start_transfer(test_name, addr, len);
                end
            join
        end else begin
            start_transfer(test_name, addr, len);
            fork
                send_stream(bytes, 1'b0);
                run_overlap_reads();
            join
        end
        while (dma_busy) begin
            @(posedge clk);
        end
        // Even byte high, odd byte low, odd tail left as zero
        for (i = 0; i < len; i++) begin
            word_addr = addr + mem_addr_t'(i / 2);
            if ((i % 2) == 0) begin
                model[word_addr] = {bytes[i], 8'h00};
            end else begin
                model[word_addr] = {model[word_addr][15:8], bytes[i]};
            end
        end
        for (i = 0; i < (len + 1) / 2; i++) begin
            word_addr = addr + mem_addr_t'(i);
            read_word(word_addr, data);
            check_value(test_name, model[word_addr], data);
        end
    endtask

    initial begin
        int idx;
        mem_data_t data;
        void'($urandom(94));
        reset <= 1'b1;
        fifo_req <= 1'b0;
        fifo_data <= '0;
        dma_start <= 1'b0;
        dma_address <= '0;
        dma_length <= '0;
        n64_req <= 1'b0;
        n64_address <= '0;
        load_vectors();
        cycle_limit = 200 * byte_pool.size() + 500;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value("reset_fifo_ack", 16'd0, {15'd0, fifo_ack});
        check_value("reset_n64_ack", 16'd0, {15'd0, n64_ack});
        check_value("reset_dma_busy", 16'd0, {15'd0, dma_busy});
        for (idx = 0; idx < cmd_kind.size(); idx++) begin
            case (cmd_kind[idx])
                "T": begin
                    run_transfer(cmd_name[idx], cmd_addr[idx], cmd_arg[idx], cmd_fast[idx]);
                end
                "R": begin
                    read_word(cmd_addr[idx], data);
                    check_value(cmd_name[idx], mem_data_t'(cmd_arg[idx]), data);
                end
                "O": begin
                    overlap_name.push_back(cmd_name[idx]);
                    overlap_addr.push_back(cmd_addr[idx]);
                    overlap_data.push_back(mem_data_t'(cmd_arg[idx]));
                end
                default: begin
                end
            endcase
        end
        $display("TEST OK");
        $finish;
    end

endmodule

// File: tests/dma_memory_asserts.sv
`timescale 1ns/1ns

module dma_memory_asserts
    import sc64_mem_pkg::*;
    import sc64_dma_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic fifo_req,
    input logic fifo_ack,
    input logic dma_mem_req,
    input mem_addr_t dma_mem_address,
    input mem_data_t dma_mem_wdata,
    input logic ram_req,
    input logic ram_write,
    input logic dma_busy,
    input arb_state_t arb_state,
    input dma_state_t dma_state
);

    // Receiver only answers a pending request
    fifo_ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(fifo_ack) |-> fifo_req)
        else $error("fifo_ack rose while fifo_req was low");

    dma_write_stable: assert property (@(posedge clk) disable iff (reset)
        (dma_mem_req && $past(dma_mem_req))
            |-> ($stable(dma_mem_address) && $stable(dma_mem_wdata)))
        else $error("DMA address or data changed during a write request");

    // Writes belong to the DMA grant and reads to the console grant
    single_grant: assert property (@(posedge clk) disable iff (reset)
        ram_req |-> (ram_write ? (arb_state == arb_grant_dma)
                               : (arb_state == arb_grant_n64)))
        else $error("RAM cycle does not match the active grant");

    dma_req_in_write: assert property (@(posedge clk) disable iff (reset)
        dma_mem_req |-> (dma_state == dma_write_req))
        else $error("DMA request outside write_req");

    idle_after_reset: assert property (@(posedge clk)
        reset |=> !dma_busy)
        else $error("DMA busy after reset");

endmodule

bind dma_memory_top dma_memory_asserts asserts_inst (
    .clk(clk),
    .reset(reset),
    .fifo_req(fifo_req),
    .fifo_ack(fifo_ack),
    .dma_mem_req(dma_mem_req),
    .dma_mem_address(dma_mem_address),
    .dma_mem_wdata(dma_mem_wdata),
    .ram_req(ram_req),
    .ram_write(ram_write),
    .dma_busy(dma_busy),
    .arb_state(memory_arbiter_inst.state),
    .dma_state(memory_dma_inst.state)
);

// File: src/dma_memory_top.sv
`timescale 1ns/1ns

module dma_memory_top
    import sc64_mem_pkg::*;
    import sc64_dma_pkg::*;
#(
    parameter int FIFO_DEPTH = 8,
    parameter int ADDR_WIDTH = 8
) (
    input logic clk,
    input logic reset,

    input logic fifo_req,
    input byte_t fifo_data,
    output logic fifo_ack,

    input logic dma_start,
    input mem_addr_t dma_address,
    input dma_length_t dma_length,
    output logic dma_busy,

    input logic n64_req,
    input mem_addr_t n64_address,
    output logic n64_ack,
    output mem_data_t n64_rdata
);

    logic rx_valid;
    byte_t rx_data;
    logic rx_pop;

    logic dma_mem_req;
    mem_addr_t dma_mem_address;
    mem_data_t dma_mem_wdata;
    logic dma_mem_ack;

    logic ram_req;
    logic ram_write;
    mem_addr_t ram_address;
    mem_data_t ram_wdata;
    logic ram_ack;
    mem_data_t ram_rdata;

    fifo_byte_rx #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_byte_rx_inst (
        .clk(clk),
        .reset(reset),

        .fifo_req(fifo_req),
        .fifo_data(fifo_data),
        .fifo_ack(fifo_ack),

        .rx_pop(rx_pop),
        .rx_valid(rx_valid),
        .rx_data(rx_data)
    );

    memory_dma memory_dma_inst (
        .clk(clk),
        .reset(reset),

        .dma_start(dma_start),
        .dma_address(dma_address),
        .dma_length(dma_length),
        .dma_busy(dma_busy),

        .rx_valid(rx_valid),
        .rx_data(rx_data),
        .rx_pop(rx_pop),

        .dma_mem_req(dma_mem_req),
        .dma_mem_address(dma_mem_address),
        .dma_mem_wdata(dma_mem_wdata),
        .dma_mem_ack(dma_mem_ack)
    );

    memory_arbiter memory_arbiter_inst (
        .clk(clk),
        .reset(reset),

        .n64_req(n64_req),
        .n64_address(n64_address),
        .n64_ack(n64_ack),
        .n64_rdata(n64_rdata),

        .dma_mem_req(dma_mem_req),
        .dma_mem_address(dma_mem_address),
        .dma_mem_wdata(dma_mem_wdata),
        .dma_mem_ack(dma_mem_ack),

        .ram_req(ram_req),
        .ram_write(ram_write),
        .ram_address(ram_address),
        .ram_wdata(ram_wdata),
        .ram_ack(ram_ack),
        .ram_rdata(ram_rdata)
    );

    memory_bram #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) memory_bram_inst (
        .clk(clk),
        .reset(reset),

        .ram_req(ram_req),
        .ram_write(ram_write),
        .ram_address(ram_address),
        .ram_wdata(ram_wdata),
        .ram_ack(ram_ack),
        .ram_rdata(ram_rdata)
    );

endmodule

// File: src/memory_bram.sv
`timescale 1ns/1ns

module memory_bram
    import sc64_mem_pkg::*;
#(
    parameter int ADDR_WIDTH = 8
) (
    input logic clk,
    input logic reset,

    input logic ram_req,
    input logic ram_write,
    input mem_addr_t ram_address,
    input mem_data_t ram_wdata,
    output logic ram_ack,
    output mem_data_t ram_rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    mem_data_t mem [DEPTH];
    logic [ADDR_WIDTH-1:0] word_index;
    logic accept;

    assign word_index = ram_address[ADDR_WIDTH-1:0];
    assign accept = ram_req && !ram_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            ram_ack <= 1'b0;
        end else if (accept) begin
            ram_ack <= 1'b1;
        end else if (!ram_req) begin
            ram_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (ram_write) begin
                mem[word_index] <= ram_wdata;
            end else begin
                ram_rdata <= mem[word_index];
            end
        end
    end

endmodule

// File: src/memory_arbiter.sv
`timescale 1ns/1ns

module memory_arbiter
    import sc64_mem_pkg::*;
    import sc64_dma_pkg::*;
(
    input logic clk,
    input logic reset,

    input logic n64_req,
    input mem_addr_t n64_address,
    output logic n64_ack,
    output mem_data_t n64_rdata,

    input logic dma_mem_req,
    input mem_addr_t dma_mem_address,
    input mem_data_t dma_mem_wdata,
    output logic dma_mem_ack,

    output logic ram_req,
    output logic ram_write,
    output mem_addr_t ram_address,
    output mem_data_t ram_wdata,
    input logic ram_ack,
    input mem_data_t ram_rdata
);

    arb_state_t state;
    logic client_ack;
    logic sel_req;

    assign sel_req = (state == arb_grant_n64) ? n64_req : dma_mem_req;
    assign n64_ack = client_ack && (state == arb_grant_n64);
    assign dma_mem_ack = client_ack && (state == arb_grant_dma);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arb_idle;
            client_ack <= 1'b0;
            ram_req <= 1'b0;
            ram_write <= 1'b0;
        end else begin
            case (state)
                arb_idle: begin
                    // Console has priority
                    if (n64_req) begin
                        state <= arb_grant_n64;
                        ram_req <= 1'b1;
                        ram_write <= 1'b0;
                    end else if (dma_mem_req) begin
                        state <= arb_grant_dma;
                        ram_req <= 1'b1;
                        ram_write <= 1'b1;
                    end
                end

                default: begin
                    if (!client_ack) begin
                        if (ram_ack) begin
                            client_ack <= 1'b1;
                        end
                    end else if (ram_req) begin
                        if (!sel_req) begin
                            ram_req <= 1'b0;
                        end
                    end else if (!ram_ack) begin
                        // Release the grant once the RAM cycle closes
                        client_ack <= 1'b0;
                        state <= arb_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == arb_idle) begin
            ram_address <= n64_req ? n64_address : dma_mem_address;
            ram_wdata <= dma_mem_wdata;
        end
        if ((state == arb_grant_n64) && ram_ack && !client_ack) begin
            n64_rdata <= ram_rdata;
        end
    end

endmodule

// File: src/memory_dma.sv
`timescale 1ns/1ns

module memory_dma
    import sc64_mem_pkg::*;
    import sc64_dma_pkg::*;
(
    input logic clk,
    input logic reset,

    input logic dma_start,
    input mem_addr_t dma_address,
    input dma_length_t dma_length,
    output logic dma_busy,

    input logic rx_valid,
    input byte_t rx_data,
    output logic rx_pop,

    output logic dma_mem_req,
    output mem_addr_t dma_mem_address,
    output mem_data_t dma_mem_wdata,
    input logic dma_mem_ack
);

    dma_state_t state;
    dma_length_t remaining;
    mem_data_t col_word;
    logic col_half;
    logic col_full;

    assign dma_busy = (state != dma_idle);

    // Collection runs one word ahead of the write in flight
    assign rx_pop = dma_busy && rx_valid && (remaining != '0) && !col_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dma_idle;
            dma_mem_req <= 1'b0;
            dma_mem_address <= '0;
            remaining <= '0;
            col_half <= 1'b0;
            col_full <= 1'b0;
        end else begin
            if (rx_pop) begin
                remaining <= remaining - 1'b1;
                // Last byte of an odd length closes a padded word
                if (!col_half && (remaining != 16'd1)) begin
                    col_half <= 1'b1;
                end else begin
                    col_half <= 1'b0;
                    col_full <= 1'b1;
                end
            end

            case (state)
                dma_idle: begin
                    if (dma_start) begin
                        remaining <= dma_length;
                        dma_mem_address <= dma_address;
                        col_half <= 1'b0;
                        col_full <= 1'b0;
                        state <= dma_collect;
                    end
                end

                dma_collect: begin
                    if (col_full) begin
                        col_full <= 1'b0;
                        dma_mem_req <= 1'b1;
                        state <= dma_write_req;
                    end else if (remaining == '0) begin
                        state <= dma_idle;
                    end
                end

                dma_write_req: begin
                    if (dma_mem_ack) begin
                        dma_mem_req <= 1'b0;
                        state <= dma_write_wait;
                    end
                end

                dma_write_wait: begin
                    if (!dma_mem_ack) begin
                        dma_mem_address <= dma_mem_address + 1'b1;
                        if ((remaining == '0) && !col_full) begin
                            state <= dma_idle;
                        end else begin
                            state <= dma_collect;
                        end
                    end
                end

                default: state <= dma_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_pop) begin
            if (!col_half) begin
                col_word <= {rx_data, 8'h00};
            end else begin
                col_word[7:0] <= rx_data;
            end
        end
        if ((state == dma_collect) && col_full) begin
            dma_mem_wdata <= col_word;
        end
    end

endmodule

// File: src/fifo_byte_rx.sv
`timescale 1ns/1ns

module fifo_byte_rx
    import sc64_mem_pkg::*;
#(
    parameter int FIFO_DEPTH = 8
) (
    input logic clk,
    input logic reset,

    input logic fifo_req,
    input byte_t fifo_data,
    output logic fifo_ack,

    input logic rx_pop,
    output logic rx_valid,
    output byte_t rx_data
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    byte_t buffer [FIFO_DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH:0] count;
    logic req_q;
    logic push;
    logic pop;

    // One byte per req phase and none while full
    assign push = req_q && !fifo_ack && (count < (PTR_WIDTH + 1)'(FIFO_DEPTH));
    assign pop = rx_pop && rx_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
            fifo_ack <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            req_q <= fifo_req;

            if (push) begin
                fifo_ack <= 1'b1;
                wr_ptr <= wr_ptr + 1'b1;
            end else if (!req_q && fifo_ack) begin
                fifo_ack <= 1'b0;
            end

            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            buffer[wr_ptr] <= fifo_data;
        end
    end

    // Head byte is visible without a pop
    assign rx_valid = (count != '0);
    assign rx_data = buffer[rd_ptr];

endmodule

// File: src/sc64_dma_pkg.sv
package sc64_dma_pkg;

    // Transfer length in bytes
    typedef logic [15:0] dma_length_t;

    // Stream to memory writer
    typedef enum logic [1:0] {
        dma_idle,
        dma_collect,
        dma_write_req,
        dma_write_wait
    } dma_state_t;

    // RAM link owner
    typedef enum logic [1:0] {
        arb_idle,
        arb_grant_n64,
        arb_grant_dma
    } arb_state_t;

endpackage

// File: src/sc64_mem_pkg.sv
package sc64_mem_pkg;

    // One byte of the host stream
    typedef logic [7:0] byte_t;

    // One RAM word packed big-endian from two stream bytes
    typedef logic [15:0] mem_data_t;

    // Word address whose low ADDR_WIDTH bits the RAM decodes
    typedef logic [15:0] mem_addr_t;

endpackage
